/* filelist.f */
+incdir+hdl
hdl/core_bus_pkg.sv
hdl/axi_lite_if.sv
hdl/mem_req_if.sv
hdl/req_arbiter.sv
hdl/axi_bus_fsm.sv
hdl/core_bus_top.sv
tb/axi_mem_model.sv
tb/tb_core_bus.sv

/* hdl/axi_bus_fsm.sv */
/*
 * AXI4-Lite bus state machine
 * Runs one single-beat read or write per granted request, builds write
 * strobes and steers byte lanes in both directions
 */

`timescale 1ns/1ns

`include "core_bus_config.svh"

module axi_bus_fsm (
    input  logic        i_clk,
    input  logic        i_rst_n,
    mem_req_if.bus      mreq,
    axi_lite_if.manager axi
);
    import core_bus_pkg::*;

    // Mealy FSM whose states name the handshakes still outstanding
    typedef enum logic [2:0] {
        IDLE,           // Also the both-pending state of a fresh write
        SEND_RADDR,     // AR still pending
        GET_RDATA,      // AR done, waiting on R
        SEND_WADDR,     // W done, AW pending
        SEND_WDATA,     // AW done, W pending
        GET_BRESP       // Both write phases done
    } state_e;

    state_e state;
    state_e next_state;

    logic aw_done;
    logic w_done;
    logic b_done;
    logic ar_done;
    logic r_done;

    // Channel handshakes in this cycle
    assign aw_done = axi.awvalid & axi.awready;
    assign w_done  = axi.wvalid  & axi.wready;
    assign b_done  = axi.bvalid  & axi.bready;
    assign ar_done = axi.arvalid & axi.arready;
    assign r_done  = axi.rvalid  & axi.rready;

    always_ff @(posedge i_clk, negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (mreq.valid && mreq.wen) begin
                    if (aw_done && w_done) next_state = GET_BRESP;
                    else if (aw_done)      next_state = SEND_WDATA;
                    else if (w_done)       next_state = SEND_WADDR;
                end else if (mreq.valid) begin
                    if (ar_done && r_done) next_state = IDLE;     // Whole read in one cycle
                    else if (ar_done)      next_state = GET_RDATA;
                    else                   next_state = SEND_RADDR;
                end
            end
            SEND_RADDR: begin
                if (ar_done && r_done) next_state = IDLE;
                else if (ar_done)      next_state = GET_RDATA;
            end
            GET_RDATA: begin
                if (r_done) next_state = IDLE;
            end
            SEND_WADDR: begin
                if (aw_done) next_state = GET_BRESP;
            end
            SEND_WDATA: begin
                if (w_done) next_state = GET_BRESP;
            end
            GET_BRESP: begin
                if (b_done) next_state = IDLE;
            end
            default: next_state = IDLE;
        endcase
    end

    // Valids and the requester ready
    always_comb begin
        axi.awvalid = 1'b0;
        axi.wvalid  = 1'b0;
        axi.arvalid = 1'b0;
        axi.rready  = 1'b0;
        mreq.ready  = 1'b0;
        case (state)
            IDLE: begin
                if (mreq.valid && mreq.wen) begin
                    axi.awvalid = 1'b1;     // Address and data launch together
                    axi.wvalid  = 1'b1;
                end else if (mreq.valid) begin
                    axi.arvalid = 1'b1;
                    axi.rready  = 1'b1;
                    mreq.ready  = ar_done & r_done;
                end
            end
            SEND_RADDR: begin
                axi.arvalid = 1'b1;
                axi.rready  = 1'b1;
                mreq.ready  = ar_done & r_done;
            end
            GET_RDATA: begin
                axi.rready = 1'b1;
                mreq.ready = r_done;
            end
            SEND_WADDR: axi.awvalid = 1'b1;
            SEND_WDATA: axi.wvalid  = 1'b1;
            GET_BRESP:  mreq.ready  = b_done;
            default: ;
        endcase
    end

    // Response can only follow the write, so B is always accepted
    assign axi.bready = 1'b1;

    // Word aligned addresses on both channels
    assign axi.awaddr = {mreq.addr[`CORE_BUS_PADDR_W-1:2], 2'b00};
    assign axi.araddr = {mreq.addr[`CORE_BUS_PADDR_W-1:2], 2'b00};

    // Strobes and replicated write data
    always_comb begin
        case (mreq.size)
            SIZE_BYTE: begin
                axi.wstrb = 4'b0001 << mreq.addr[1:0];      // One lane by offset
                axi.wdata = {4{mreq.wdata[7:0]}};
            end
            SIZE_HALFWORD: begin
                axi.wstrb = mreq.addr[1] ? 4'b1100 : 4'b0011;
                axi.wdata = {2{mreq.wdata[15:0]}};
            end
            default: begin
                axi.wstrb = 4'b1111;
                axi.wdata = mreq.wdata;
            end
        endcase
    end

    // Zero extended read lane extraction
    always_comb begin
        case (mreq.size)
            SIZE_BYTE: begin
                case (mreq.addr[1:0])
                    2'd0:    mreq.rdata = {24'h0, axi.rdata[7:0]};
                    2'd1:    mreq.rdata = {24'h0, axi.rdata[15:8]};
                    2'd2:    mreq.rdata = {24'h0, axi.rdata[23:16]};
                    default: mreq.rdata = {24'h0, axi.rdata[31:24]};
                endcase
            end
            SIZE_HALFWORD: begin
                mreq.rdata = mreq.addr[1] ? {16'h0, axi.rdata[31:16]}
                                          : {16'h0, axi.rdata[15:0]};
            end
            default: mreq.rdata = axi.rdata;
        endcase
    end

endmodule : axi_bus_fsm

/* hdl/axi_lite_if.sv */
/*
 * AXI4-Lite bus bundle
 * Five single-beat channels with manager and subordinate views
 */

`timescale 1ns/1ns

`include "core_bus_config.svh"

interface axi_lite_if;
    import core_bus_pkg::*;

    // Write address channel
    logic   awvalid;
    logic   awready;
    paddr_t awaddr;

    // Write data channel
    logic   wvalid;
    logic   wready;
    word_t  wdata;
    logic   [`CORE_BUS_DATA_W/8-1:0] wstrb;    // One bit per byte lane

    // Write response channel without a response code
    logic   bvalid;
    logic   bready;

    // Read address channel
    logic   arvalid;
    logic   arready;
    paddr_t araddr;

    // Read data channel
    logic   rvalid;
    logic   rready;
    word_t  rdata;

    // Core side drives requests
    modport manager (
        output awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
        input  awready, wready, bvalid, arready, rvalid, rdata
    );

    // Memory side answers them
    modport subordinate (
        input  awvalid, awaddr, wvalid, wdata, wstrb, bready, arvalid, araddr, rready,
        output awready, wready, bvalid, arready, rvalid, rdata
    );

endinterface : axi_lite_if

/* hdl/core_bus_config.svh */
/*
 * Core memory bus configuration
 * Requester count and bus widths shared by the package, RTL and testbench
 */

`ifndef CORE_BUS_CONFIG_SVH
`define CORE_BUS_CONFIG_SVH

// MMU walker, instruction cache and data cache
`define CORE_BUS_NUM_REQ 3

// Physical address width in bits
`define CORE_BUS_PADDR_W 32

// Data word width in bits
// The four-lane strobe logic assumes 32 bits here
`define CORE_BUS_DATA_W 32

`endif

/* hdl/core_bus_pkg.sv */
/*
 * Core memory bus package
 * Access size encoding plus address, data and requester index types
 */

`include "core_bus_config.svh"

package core_bus_pkg;

    // Access size of one request
    typedef enum logic [1:0] {
        SIZE_BYTE     = 2'b00,
        SIZE_HALFWORD = 2'b01,
        SIZE_WORD     = 2'b10
    } size_e;

    // Physical byte address
    typedef logic [`CORE_BUS_PADDR_W-1:0] paddr_t;

    // One bus data word
    typedef logic [`CORE_BUS_DATA_W-1:0] word_t;

    // Index width for requesters
    // Kept at one bit or more so a single requester still gets a legal type
    localparam int REQ_IDX_W = (`CORE_BUS_NUM_REQ > 1) ? $clog2(`CORE_BUS_NUM_REQ) : 1;

    // Requester index as used by the arbiter
    typedef logic [REQ_IDX_W-1:0] req_idx_t;

endpackage : core_bus_pkg

/* hdl/core_bus_top.sv */
/*
 * Core memory bus top level
 * Shares one AXI4-Lite manager port among the internal requesters
 */

`timescale 1ns/1ns

`include "core_bus_config.svh"

module core_bus_top (
    input  logic                                         i_clk,
    input  logic                                         i_rst_n,
    // Requester side with one bit or lane per requester
    input  logic                 [`CORE_BUS_NUM_REQ-1:0] i_req_valid,
    input  logic                 [`CORE_BUS_NUM_REQ-1:0] i_req_wen,
    input  core_bus_pkg::size_e  [`CORE_BUS_NUM_REQ-1:0] i_req_size,
    input  core_bus_pkg::paddr_t [`CORE_BUS_NUM_REQ-1:0] i_req_addr,
    input  core_bus_pkg::word_t  [`CORE_BUS_NUM_REQ-1:0] i_req_wdata,
    output logic                 [`CORE_BUS_NUM_REQ-1:0] o_req_ready,
    output core_bus_pkg::word_t                          o_req_rdata,
    // AXI4-Lite manager port
    output logic                                         o_awvalid,
    input  logic                                         i_awready,
    output core_bus_pkg::paddr_t                         o_awaddr,
    output logic                                         o_wvalid,
    input  logic                                         i_wready,
    output core_bus_pkg::word_t                          o_wdata,
    output logic                 [`CORE_BUS_DATA_W/8-1:0] o_wstrb,
    input  logic                                         i_bvalid,
    output logic                                         o_bready,
    output logic                                         o_arvalid,
    input  logic                                         i_arready,
    output core_bus_pkg::paddr_t                         o_araddr,
    input  logic                                         i_rvalid,
    output logic                                         o_rready,
    input  core_bus_pkg::word_t                          i_rdata
);

    mem_req_if  mreq0 ();
    axi_lite_if axi0 ();

    req_arbiter arb0 (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_req_valid (i_req_valid),
        .i_req_wen   (i_req_wen),
        .i_req_size  (i_req_size),
        .i_req_addr  (i_req_addr),
        .i_req_wdata (i_req_wdata),
        .o_req_ready (o_req_ready),
        .o_req_rdata (o_req_rdata),
        .mreq        (mreq0.requester)
    );

    axi_bus_fsm fsm0 (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .mreq    (mreq0.bus),
        .axi     (axi0.manager)
    );

    // Flatten the AXI bundle onto plain ports
    assign o_awvalid     = axi0.awvalid;
    assign o_awaddr      = axi0.awaddr;
    assign axi0.awready  = i_awready;
    assign o_wvalid      = axi0.wvalid;
    assign o_wdata       = axi0.wdata;
    assign o_wstrb       = axi0.wstrb;
    assign axi0.wready   = i_wready;
    assign axi0.bvalid   = i_bvalid;
    assign o_bready      = axi0.bready;
    assign o_arvalid     = axi0.arvalid;
    assign o_araddr      = axi0.araddr;
    assign axi0.arready  = i_arready;
    assign axi0.rvalid   = i_rvalid;
    assign axi0.rdata    = i_rdata;
    assign o_rready      = axi0.rready;

endmodule : core_bus_top

/* hdl/mem_req_if.sv */
/*
 * Granted memory request link
 * Carries the one request that the arbiter passes to the bus FSM
 */

`timescale 1ns/1ns

interface mem_req_if;
    import core_bus_pkg::*;

    logic   valid;  // Grant held with stable fields
    logic   wen;    // High for a write
    size_e  size;
    paddr_t addr;   // Byte address whose low bits pick lanes
    word_t  wdata;
    logic   ready;  // One cycle at the end of a transfer
    word_t  rdata;  // Only meaningful with ready

    // Arbiter side
    modport requester (
        output valid, wen, size, addr, wdata,
        input  ready, rdata
    );

    // Bus FSM side
    modport bus (
        input  valid, wen, size, addr, wdata,
        output ready, rdata
    );

endinterface : mem_req_if

/* hdl/req_arbiter.sv */
/*
 * Locked round-robin request arbiter
 * Picks the next valid requester after the last one served and holds
 * the grant until its transfer completes
 */

`timescale 1ns/1ns

`include "core_bus_config.svh"

module req_arbiter (
    input  logic                                        i_clk,
    input  logic                                        i_rst_n,
    input  logic                 [`CORE_BUS_NUM_REQ-1:0] i_req_valid,
    input  logic                 [`CORE_BUS_NUM_REQ-1:0] i_req_wen,
    input  core_bus_pkg::size_e  [`CORE_BUS_NUM_REQ-1:0] i_req_size,
    input  core_bus_pkg::paddr_t [`CORE_BUS_NUM_REQ-1:0] i_req_addr,
    input  core_bus_pkg::word_t  [`CORE_BUS_NUM_REQ-1:0] i_req_wdata,
    output logic                 [`CORE_BUS_NUM_REQ-1:0] o_req_ready,
    output core_bus_pkg::word_t                          o_req_rdata,
    mem_req_if.requester                                 mreq
);
    import core_bus_pkg::*;

    req_idx_t grant_idx;    // Requester currently owning the bus
    req_idx_t last_idx;     // Last requester served
    req_idx_t pick_idx;
    logic     grant_active;
    logic     pick_found;

    // Search starts one past the last served requester and wraps
    always_comb begin
        int cand;
        pick_found = 1'b0;
        pick_idx   = last_idx;
        for (int k = 1; k <= `CORE_BUS_NUM_REQ; k++) begin
            cand = (int'(last_idx) + k) % `CORE_BUS_NUM_REQ;
            if (!pick_found && i_req_valid[cand]) begin
                pick_found = 1'b1;
                pick_idx   = req_idx_t'(cand);
            end
        end
    end

    always_ff @(posedge i_clk, negedge i_rst_n) begin
        if (!i_rst_n) begin
            grant_active <= 1'b0;
            grant_idx    <= '0;
            last_idx     <= req_idx_t'(`CORE_BUS_NUM_REQ - 1);   // Requester 0 goes first
        end else if (!grant_active) begin
            if (pick_found) begin
                grant_active <= 1'b1;
                grant_idx    <= pick_idx;
            end
        end else if (mreq.ready) begin
            grant_active <= 1'b0;       // Release right after the handshake
            last_idx     <= grant_idx;
        end
    end

    // Forward the granted requester's fields
    assign mreq.valid = grant_active;
    assign mreq.wen   = i_req_wen[grant_idx];
    assign mreq.size  = i_req_size[grant_idx];
    assign mreq.addr  = i_req_addr[grant_idx];
    assign mreq.wdata = i_req_wdata[grant_idx];

    // Ready goes back to the owner only
    always_comb begin
        o_req_ready            = '0;
        o_req_ready[grant_idx] = mreq.ready;
    end

    assign o_req_rdata = mreq.rdata;    // Same word for everybody

endmodule : req_arbiter

/* run_sim.sh */
#!/bin/sh
# Build the core bus testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing -f filelist.f --top-module tb_core_bus -o sim_core_bus &&
out="$(./obj_dir/sim_core_bus)" &&
echo "$out" &&
echo "$out" | grep -q "ALL CHECKS PASSED" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

/* tb/axi_mem_model.sv */
/*
 * AXI4-Lite memory for the bus testbench
 * Sixteen words with random ready and response stalls from a seed
 */

`timescale 1ns/1ns

module axi_mem_model #(
    parameter logic [31:0] SEED = 32'h0
) (
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_awvalid,
    output logic        o_awready,
    input  logic [31:0] i_awaddr,
    input  logic        i_wvalid,
    output logic        o_wready,
    input  logic [31:0] i_wdata,
    input  logic [3:0]  i_wstrb,
    output logic        o_bvalid,
    input  logic        i_bready,
    input  logic        i_arvalid,
    output logic        o_arready,
    input  logic [31:0] i_araddr,
    output logic        o_rvalid,
    input  logic        i_rready,
    output logic [31:0] o_rdata
);
    logic [31:0] mem [16];
    logic [31:0] seed;
    logic [31:0] w_data;
    logic [3:0]  w_strb;
    logic [3:0]  aw_idx;
    logic [3:0]  ar_idx;
    logic        aw_have;   // Address taken and waiting for B
    logic        w_have;
    logic        b_pend;    // Write applied with its response owed
    logic        ar_have;

    // Roughly one cycle in four stalls
    function automatic logic go();
        logic [31:0] rnd;
        rnd = $random(seed);
        return rnd[1:0] != 2'd0;
    endfunction

    initial begin
        seed = SEED;
        for (int i = 0; i < 16; i++) begin
            mem[i] = (i * 32'h9e3779b9) ^ 32'ha5a5a5a5;     // Differs for every word
        end
        {o_awready, o_wready, o_bvalid, o_arready, o_rvalid} = '0;
        {aw_have, w_have, b_pend, ar_have} = '0;
        o_rdata = '0;
        forever begin
            @(negedge i_clk);                               // Handshakes settled here
            if (!i_rst_n) {aw_have, w_have, b_pend, ar_have} = '0;
            if (o_bvalid && i_bready) {aw_have, w_have, b_pend} = '0;
            if (o_rvalid && i_rready) ar_have = 1'b0;
            if (i_awvalid && o_awready) begin
                aw_have = 1'b1;
                aw_idx  = i_awaddr[5:2];
            end
            if (i_wvalid && o_wready) begin
                w_have = 1'b1;
                w_data = i_wdata;
                w_strb = i_wstrb;
            end
            if (i_arvalid && o_arready) begin
                ar_have = 1'b1;
                ar_idx  = i_araddr[5:2];
            end
            if (aw_have && w_have && !b_pend) begin
                for (int k = 0; k < 4; k++) begin
                    if (w_strb[k]) mem[aw_idx][8*k +: 8] = w_data[8*k +: 8];
                end
                b_pend = 1'b1;
            end
            @(posedge i_clk);
            #1;
            o_awready = i_rst_n && !aw_have && go();       // One write at a time
            o_wready  = i_rst_n && !w_have && go();
            o_arready = i_rst_n && !ar_have && go();
            o_bvalid  = b_pend && (o_bvalid || go());       // Held until taken
            o_rvalid  = ar_have && (o_rvalid || go());
            if (o_rvalid) o_rdata = mem[ar_idx];
        end
    end

endmodule : axi_mem_model

/* tb/tb_core_bus.sv */
/*
 * Testbench for the core memory bus
 * Directed and random request rounds against a stalling AXI memory,
 * checked with a reference memory and a round-robin order model
 */

`timescale 1ns/1ns

`include "core_bus_config.svh"

module tb_core_bus;
    import core_bus_pkg::*;

    localparam int          NREQ    = `CORE_BUS_NUM_REQ;
    localparam int          NROUNDS = 80;
    localparam int          NXFER   = 5 * NREQ + NROUNDS * NREQ;   // Upper bound of transfers
    localparam logic [31:0] SEED    = 32'h4bb9b225;

    logic clk;
    logic rst_n;
    logic                 [NREQ-1:0] req_valid;
    logic                 [NREQ-1:0] req_wen;
    size_e                [NREQ-1:0] req_size;
    paddr_t               [NREQ-1:0] req_addr;
    word_t                [NREQ-1:0] req_wdata;
    logic                 [NREQ-1:0] req_ready;
    word_t                           req_rdata;
    logic   awvalid, awready, wvalid, wready, bvalid, bready;
    logic   arvalid, arready, rvalid, rready;
    paddr_t awaddr, araddr;
    word_t  wdata, rdata;
    logic   [3:0] wstrb;

    logic [31:0] seed;
    logic [NREQ-1:0] pending;   // Requests issued but not yet served
    word_t ref_mem [16];
    int    last_idx;
    int    errors = 0;
    int    wr_done = 0;
    int    rd_done = 0;
    int    aw_cnt = 0;
    int    w_cnt = 0;
    int    b_cnt = 0;
    int    ar_cnt = 0;
    int    r_cnt = 0;

    core_bus_top dut0 (
        .i_clk(clk), .i_rst_n(rst_n),
        .i_req_valid(req_valid), .i_req_wen(req_wen), .i_req_size(req_size),
        .i_req_addr(req_addr), .i_req_wdata(req_wdata),
        .o_req_ready(req_ready), .o_req_rdata(req_rdata),
        .o_awvalid(awvalid), .i_awready(awready), .o_awaddr(awaddr),
        .o_wvalid(wvalid), .i_wready(wready), .o_wdata(wdata), .o_wstrb(wstrb),
        .i_bvalid(bvalid), .o_bready(bready),
        .o_arvalid(arvalid), .i_arready(arready), .o_araddr(araddr),
        .i_rvalid(rvalid), .o_rready(rready), .i_rdata(rdata)
    );

    axi_mem_model #(.SEED(SEED)) mem0 (
        .i_clk(clk), .i_rst_n(rst_n),
        .i_awvalid(awvalid), .o_awready(awready), .i_awaddr(awaddr),
        .i_wvalid(wvalid), .o_wready(wready), .i_wdata(wdata), .i_wstrb(wstrb),
        .o_bvalid(bvalid), .i_bready(bready),
        .i_arvalid(arvalid), .o_arready(arready), .i_araddr(araddr),
        .o_rvalid(rvalid), .i_rready(rready), .o_rdata(rdata)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // 400 cycles of 4 ns for every planned transfer
    initial begin
        #(NXFER * 400 * 4);
        $display("Timeout: requests still waiting for o_req_ready");
        $display("CHECKS FAILED");
        $finish;
    end

    // Channel handshake counts and ready one-hot check
    always @(negedge clk) begin
        if (awvalid && awready) aw_cnt++;
        if (wvalid && wready) w_cnt++;
        if (bvalid && bready) b_cnt++;
        if (arvalid && arready) ar_cnt++;
        if (rvalid && rready) r_cnt++;
        assert ($onehot0(req_ready)) else begin
            errors++;
            $display("o_req_ready has several bits set (%b) at %0t", req_ready, $time);
        end
    end

    function automatic logic [31:0] rand32();
        return $random(seed);
    endfunction

    // Lowest byte lane touched by an access
    function automatic int first_lane(size_e sz, paddr_t a);
        if (sz == SIZE_BYTE) return int'(a[1:0]);
        if (sz == SIZE_HALFWORD) return 2 * int'(a[1]);
        return 0;
    endfunction

    function automatic int lane_count(size_e sz);
        return (sz == SIZE_BYTE) ? 1 : (sz == SIZE_HALFWORD) ? 2 : 4;
    endfunction

    function automatic void ref_write(paddr_t a, size_e sz, word_t d);
        int lane;
        lane = first_lane(sz, a);
        for (int k = 0; k < lane_count(sz); k++) begin
            ref_mem[a[5:2]][8*(lane+k) +: 8] = d[8*k +: 8];
        end
    endfunction

    // Addressed lanes shifted down with the upper bits zero
    function automatic word_t ref_read(paddr_t a, size_e sz);
        word_t w;
        w = ref_mem[a[5:2]] >> (8 * first_lane(sz, a));
        if (sz == SIZE_BYTE) return w & 32'h0000_00ff;
        if (sz == SIZE_HALFWORD) return w & 32'h0000_ffff;
        return w;
    endfunction

    // First waiting requester after the last one served
    function automatic int next_requester(logic [NREQ-1:0] waiting, int last);
        int cand;
        for (int k = 1; k <= NREQ; k++) begin
            cand = (last + k) % NREQ;
            if (waiting[cand]) return cand;
        end
        return -1;
    endfunction

    task automatic set_req(input int r, input logic wen, input size_e sz,
                           input paddr_t a, input word_t d);
        req_wen[r]   = wen;
        req_size[r]  = sz;
        req_addr[r]  = a;
        req_wdata[r] = d;
    endtask

    task automatic check_idle_outputs(input string phase);
        assert (req_ready == '0 && !arvalid && !awvalid && !wvalid && !rready) else begin
            errors++;
            $display("Bus outputs not idle %s at %0t", phase, $time);
        end
    endtask

    // Raise the masked valids together and follow each ready pulse
    task automatic run_round(input logic [NREQ-1:0] mask);
        int idx;
        int exp_idx;
        word_t exp_data;
        paddr_t exp_addr;
        paddr_t aw_seen;
        paddr_t ar_seen;
        req_valid = mask;
        pending   = mask;
        aw_seen   = '0;
        ar_seen   = '0;
        while (pending != '0) begin
            @(negedge clk);
            if (awvalid && awready) aw_seen = awaddr;   // Address of the write in flight
            if (arvalid && arready) ar_seen = araddr;
            if (req_ready != '0) begin
                idx      = $clog2(req_ready);
                exp_idx  = next_requester(pending, last_idx);
                exp_addr = {req_addr[idx][31:2], 2'b00};    // Bus sees whole words
                assert (pending[idx]) else begin
                    errors++;
                    $display("Requester %0d got ready with no request at %0t", idx, $time);
                end
                assert (idx == exp_idx) else begin
                    errors++;
                    $display("[FAIL] %0t o_req_ready: expected requester %0d, got %0d",
                             $time, exp_idx, idx);
                end
                if (pending[idx] && req_wen[idx]) begin
                    assert (aw_seen == exp_addr) else begin
                        errors++;
                        $display("[FAIL] %0t o_awaddr: expected %h, got %h",
                                 $time, exp_addr, aw_seen);
                    end
                    ref_write(req_addr[idx], req_size[idx], req_wdata[idx]);
                    wr_done++;
                end else if (pending[idx]) begin
                    assert (ar_seen == exp_addr) else begin
                        errors++;
                        $display("[FAIL] %0t o_araddr: expected %h, got %h",
                                 $time, exp_addr, ar_seen);
                    end
                    exp_data = ref_read(req_addr[idx], req_size[idx]);
                    assert (req_rdata == exp_data) else begin
                        errors++;
                        $display("[FAIL] %0t o_req_rdata: expected %h, got %h",
                                 $time, exp_data, req_rdata);
                    end
                    rd_done++;
                end
                pending[idx] = 1'b0;
                last_idx     = idx;
                @(posedge clk);
                #1;
                req_valid[idx] = 1'b0;          // Requester lets go after its ready
            end
        end
    endtask

    initial begin
        logic [31:0]     rnd;
        logic [NREQ-1:0] mask;
        seed      = SEED;
        rst_n     = 1'b0;
        req_valid = '0;
        req_wen   = '0;
        req_size  = '{default: SIZE_WORD};
        req_addr  = '0;
        req_wdata = '0;
        pending   = '0;
        last_idx  = NREQ - 1;                   // Requester 0 has first turn after reset
        @(negedge clk);
        check_idle_outputs("during reset");
        @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(negedge clk);
        check_idle_outputs("after reset");
        for (int i = 0; i < 16; i++) ref_mem[i] = mem0.mem[i];
        @(posedge clk);
        #1;

        // Word write and read back, then subword writes and reads
        set_req(0, 1'b1, SIZE_WORD, 32'h08, 32'h1234_5678);
        run_round(3'b001);
        set_req(0, 1'b0, SIZE_WORD, 32'h08, 32'h0);
        run_round(3'b001);
        set_req(1, 1'b1, SIZE_BYTE, 32'h09, 32'h0000_00ab);
        set_req(2, 1'b1, SIZE_HALFWORD, 32'h0e, 32'h0000_cdef);
        run_round(3'b110);
        set_req(0, 1'b0, SIZE_WORD, 32'h08, 32'h0);
        set_req(1, 1'b0, SIZE_WORD, 32'h0c, 32'h0);
        run_round(3'b011);
        set_req(1, 1'b0, SIZE_HALFWORD, 32'h0e, 32'h0);
        set_req(2, 1'b0, SIZE_BYTE, 32'h0b, 32'h0);
        run_round(3'b110);

        // Random rounds over a small window so addresses collide often
        for (int n = 0; n < NROUNDS; n++) begin
            do begin
                rnd  = rand32();
                mask = rnd[NREQ-1:0];
            end while (mask == '0);
            for (int r = 0; r < NREQ; r++) begin
                rnd = rand32();
                set_req(r, rnd[8], (rnd[1:0] == 2'd0) ? SIZE_BYTE :
                        (rnd[1:0] == 2'd1) ? SIZE_HALFWORD : SIZE_WORD,
                        {26'h0, rnd[7:2]}, rand32());
            end
            run_round(mask);
        end

        repeat (4) @(posedge clk);
        assert (aw_cnt == wr_done && w_cnt == wr_done && b_cnt == wr_done) else begin
            errors++;
            $display("Write handshakes %0d AW, %0d W, %0d B do not match %0d writes",
                     aw_cnt, w_cnt, b_cnt, wr_done);
        end
        assert (ar_cnt == rd_done && r_cnt == rd_done) else begin
            errors++;
            $display("Read handshakes %0d AR, %0d R do not match %0d reads",
                     ar_cnt, r_cnt, rd_done);
        end

        // Every written lane must have landed, read back or not
        for (int i = 0; i < 16; i++) begin
            assert (mem0.mem[i] == ref_mem[i]) else begin
                errors++;
                $display("[FAIL] %0t mem0.mem[%0d]: expected %h, got %h",
                         $time, i, ref_mem[i], mem0.mem[i]);
            end
        end
        $display("Summary: %0d errors, %0d reads, %0d writes", errors, rd_done, wr_done);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule : tb_core_bus
